// ==== Bender.yml ====
package:
  name: scc_dual

export_include_dirs:
  - design

sources:
  - files:
      - design/msx_bus_pkg.sv
      - design/scc_pkg.sv
      - design/scc_wave_mem_if.sv
      - design/scc_reg_port.sv
      - design/scc_voice_seq.sv
      - design/scc_wave_arb.sv
      - design/scc_wave.sv
      - design/scc_top.sv
  - target: test
    files:
      - test/scc_assert.sv
      - test/scc_tb.sv

// ==== compile.f ====
+incdir+design
design/msx_bus_pkg.sv
design/scc_pkg.sv
design/scc_wave_mem_if.sv
design/scc_reg_port.sv
design/scc_voice_seq.sv
design/scc_wave_arb.sv
design/scc_wave.sv
design/scc_top.sv
test/scc_assert.sv
test/scc_tb.sv

// ==== design/msx_bus_pkg.sv ====
package msx_bus_pkg;

    // CPU side of the sound cartridge
    typedef logic [7:0] bus_addr_t;   // Register offset inside the chip window
    typedef logic [7:0] bus_byte_t;   // CPU data byte

    // Device kinds seen on the configuration bus
    typedef enum logic [2:0] {
        DEV_NONE      = 3'd0,
        DEV_OPL3      = 3'd1,
        DEV_SCC       = 3'd2,
        DEV_PSG       = 3'd3,
        DEV_MSX_MUSIC = 3'd4,
        DEV_MSX_AUDIO = 3'd5
    } dev_type_t;

    typedef logic [1:0] dev_num_t;    // Instance number of a device kind

endpackage

// ==== design/scc_config.svh ====
`ifndef SCC_CONFIG_SVH
`define SCC_CONFIG_SVH

// Voices per chip and bytes per waveform table
`define SCC_NUM_VOICES 5
`define SCC_WAVE_DEPTH 32

// SCC chips on the device bus
`define SCC_NUM_CHIPS 2

// CPU register map
`define SCC_PERIOD_BASE 8'h80      // Five period pairs, low byte then high nibble
`define SCC_VOLUME_BASE 8'h8A      // Five volume nibbles
`define SCC_ENABLE_ADDR 8'h8F      // One enable bit per voice
`define SCC_PLUS_WAVE4_BASE 8'hA0  // Voice 4 table window in SCC+ mode

`endif

// ==== design/scc_pkg.sv ====
package scc_pkg;

    // Waveform memory
    typedef logic signed [7:0] wave_sample_t;   // One signed table entry
    typedef logic [7:0]        wave_index_t;    // Flat RAM index, 0 to 159

    // Per-voice controls
    typedef logic [11:0] voice_period_t;        // Ticks between table steps
    typedef logic [3:0]  voice_volume_t;        // Linear gain, 0 to 15

    // Audio outputs
    typedef logic signed [14:0] chip_wave_t;    // Sum of one chip's voices
    typedef logic signed [15:0] mix_sample_t;   // Both chips together

    // Sample sweep after each tick
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,   // Waiting for the next clk_en
        SEQ_FETCH = 2'd1,   // Requesting one voice's sample
        SEQ_ACCUM = 2'd2    // Sample back, adding its share
    } seq_state_t;

endpackage

// ==== design/scc_reg_port.sv ====
`timescale 1ns/1ns
`include "scc_config.svh"

module scc_reg_port (
    input  logic                    cpu_bus,
    input  logic                    rst_n,
    input  logic                    sel,                           // Chip picked on the device bus
    input  logic                    rd,
    input  logic                    wr,
    input  msx_bus_pkg::bus_addr_t  addr,
    input  msx_bus_pkg::bus_byte_t  wdata,
    input  logic                    plus_mode,                     // SCC+ map active
    scc_wave_mem_if.requester       mem,
    output scc_pkg::voice_period_t  periods [`SCC_NUM_VOICES],
    output scc_pkg::voice_volume_t  volumes [`SCC_NUM_VOICES],
    output logic [`SCC_NUM_VOICES-1:0] voice_en,
    output msx_bus_pkg::bus_byte_t  rdata,
    output logic                    rvalid
);

    localparam scc_pkg::wave_index_t WAVE4_SLOT = 8'(4 * `SCC_WAVE_DEPTH);  // Voice 4 table start

    logic                 is_wave_lo;  // Tables 0 to 3 window
    logic                 is_wave4;    // Voice 4 window, plus mode only
    logic                 is_mirror;   // Voice 3 table in plain mode
    scc_pkg::wave_index_t wave_idx;
    logic                 dup_pend;    // Voice 4 copy still owed
    logic                 wave_rd_q;   // Table byte returns this cycle
    logic                 reg_rd_q;    // Register read answers this cycle

    assign is_wave_lo = addr < `SCC_PERIOD_BASE;
    assign is_wave4   = plus_mode && addr >= `SCC_PLUS_WAVE4_BASE &&
                        addr < (`SCC_PLUS_WAVE4_BASE + `SCC_WAVE_DEPTH);
    assign is_mirror  = !plus_mode && is_wave_lo && addr[6:5] == 2'd3;
    assign wave_idx   = is_wave4 ? WAVE4_SLOT + scc_pkg::wave_index_t'(addr[4:0]) : addr;

    // Period, volume and enable registers
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SCC_NUM_VOICES; i++) begin
                periods[i] <= '0;
                volumes[i] <= '0;
            end
            voice_en <= '0;
        end else if (sel && wr) begin
            for (int i = 0; i < `SCC_NUM_VOICES; i++) begin
                if (addr == msx_bus_pkg::bus_addr_t'(`SCC_PERIOD_BASE + 2 * i))
                    periods[i][7:0] <= wdata;                     // Fine part
                if (addr == msx_bus_pkg::bus_addr_t'(`SCC_PERIOD_BASE + 2 * i + 1))
                    periods[i][11:8] <= wdata[3:0];               // Coarse nibble
                if (addr == msx_bus_pkg::bus_addr_t'(`SCC_VOLUME_BASE + i))
                    volumes[i] <= wdata[3:0];
            end
            if (addr == `SCC_ENABLE_ADDR)
                voice_en <= wdata[`SCC_NUM_VOICES-1:0];
        end
    end

    // Memory request and read-return flags
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            mem.req   <= 1'b0;
            dup_pend  <= 1'b0;
            wave_rd_q <= 1'b0;
            reg_rd_q  <= 1'b0;
        end else begin
            wave_rd_q <= mem.req && mem.grant && !mem.we;
            reg_rd_q  <= sel && rd && !(is_wave_lo || is_wave4);
            if (mem.req && mem.grant) begin
                if (dup_pend) dup_pend <= 1'b0;                   // Keep req for the copy
                else mem.req <= 1'b0;
            end else if (sel && (rd || wr) && (is_wave_lo || is_wave4)) begin
                mem.req  <= 1'b1;
                dup_pend <= wr && is_mirror;
            end
        end
    end

    // Request payload, second write retargets to voice 4
    always_ff @(posedge cpu_bus) begin
        if (mem.req && mem.grant) begin
            mem.addr <= WAVE4_SLOT + scc_pkg::wave_index_t'(mem.addr[4:0]);
        end else if (sel && (rd || wr)) begin
            mem.we    <= wr;
            mem.addr  <= wave_idx;
            mem.wdata <= scc_pkg::wave_sample_t'(wdata);
        end
    end

    assign rvalid = wave_rd_q || reg_rd_q;
    assign rdata  = wave_rd_q ? msx_bus_pkg::bus_byte_t'(mem.rdata) : 8'hFF;  // Open bus otherwise

endmodule

// ==== design/scc_top.sv ====
`timescale 1ns/1ns
`include "scc_config.svh"

module scc_top (
    input  logic                   cpu_bus,
    input  logic                   rst_n,
    input  logic                   clk_en,
    input  logic                   rd,
    input  logic                   wr,
    input  msx_bus_pkg::bus_addr_t addr,
    input  msx_bus_pkg::bus_byte_t wdata,
    input  msx_bus_pkg::dev_type_t dev_typ,
    input  msx_bus_pkg::dev_num_t  dev_num,
    input  logic                   dev_en,
    input  logic                   dev_mode,
    input  logic                   dev_param,
    input  logic [1:0]             mix_enable,   // Per-chip share in the mix
    output scc_pkg::mix_sample_t   sound,
    output msx_bus_pkg::bus_byte_t data,
    output logic                   output_rq
);

    logic [`SCC_NUM_CHIPS-1:0] scc_mode;         // SCC+ map requested
    logic [`SCC_NUM_CHIPS-1:0] scc_plus;         // Chip is an SCC+
    logic [`SCC_NUM_CHIPS-1:0] sel;
    logic [`SCC_NUM_CHIPS-1:0] chip_rvalid;
    scc_pkg::chip_wave_t       chip_wave  [`SCC_NUM_CHIPS];
    msx_bus_pkg::bus_byte_t    chip_rdata [`SCC_NUM_CHIPS];

    // Chip flags loaded from the device bus
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            scc_mode <= '0;
            scc_plus <= '0;
        end else if (dev_typ == msx_bus_pkg::DEV_SCC && dev_num < `SCC_NUM_CHIPS) begin
            scc_mode[dev_num[0]] <= dev_mode;
            scc_plus[dev_num[0]] <= dev_param;
        end
    end

    for (genvar i = 0; i < `SCC_NUM_CHIPS; i++) begin : g_chip
        assign sel[i] = dev_en && dev_typ == msx_bus_pkg::DEV_SCC && dev_num == i;

        scc_wave u_scc_wave (
            .cpu_bus, .rst_n, .clk_en,
            .sel       (sel[i]),
            .rd, .wr, .addr, .wdata,
            .plus_chip (scc_plus[i]),
            .plus_mode (scc_mode[i]),
            .wave      (chip_wave[i]),
            .rdata     (chip_rdata[i]),
            .rvalid    (chip_rvalid[i])
        );
    end

    // Read return, accesses never overlap so at most one chip answers
    assign output_rq = |chip_rvalid;
    assign data = chip_rvalid[0] ? chip_rdata[0] :
                  chip_rvalid[1] ? chip_rdata[1] : 8'hFF;

    // Sign-extended chip waves under mix enables
    assign sound = (mix_enable[0] ? scc_pkg::mix_sample_t'(chip_wave[0]) : '0) +
                   (mix_enable[1] ? scc_pkg::mix_sample_t'(chip_wave[1]) : '0);

endmodule

// ==== design/scc_voice_seq.sv ====
`timescale 1ns/1ns
`include "scc_config.svh"

module scc_voice_seq (
    input  logic                   cpu_bus,
    input  logic                   rst_n,
    input  logic                   clk_en,                        // Sample tick
    input  scc_pkg::voice_period_t periods [`SCC_NUM_VOICES],
    input  scc_pkg::voice_volume_t volumes [`SCC_NUM_VOICES],
    input  logic [`SCC_NUM_VOICES-1:0] voice_en,
    input  logic                   plus_mode,                     // Voice 4 owns its table
    scc_wave_mem_if.requester      mem,
    output scc_pkg::chip_wave_t    wave
);

    localparam logic [2:0] LAST_VOICE = 3'(`SCC_NUM_VOICES - 1);
    localparam int PTR_W = $clog2(`SCC_WAVE_DEPTH);

    scc_pkg::voice_period_t cnt [`SCC_NUM_VOICES];   // Ticks left until next step
    logic [PTR_W-1:0]       ptr [`SCC_NUM_VOICES];   // Position inside each table
    scc_pkg::seq_state_t    state;
    logic [2:0]             voice;                   // Voice being fetched
    scc_pkg::chip_wave_t    acc;                     // Running sum of the sweep
    logic signed [12:0]     prod;
    scc_pkg::chip_wave_t    contrib;                 // Share of the current voice

    // Table byte address, plain mode folds voice 4 onto table 3
    function automatic scc_pkg::wave_index_t fetch_addr(input logic [2:0] v,
                                                        input logic [PTR_W-1:0] p,
                                                        input logic plus);
        logic [2:0] tbl;
        tbl = (v == LAST_VOICE && !plus) ? 3'd3 : v;
        return scc_pkg::wave_index_t'({tbl, p});
    endfunction

    // Period counters, one step per expiry
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SCC_NUM_VOICES; i++) begin
                cnt[i] <= '0;
                ptr[i] <= '0;
            end
        end else if (clk_en) begin
            for (int i = 0; i < `SCC_NUM_VOICES; i++) begin
                if (voice_en[i]) begin
                    if (cnt[i] == '0) begin
                        cnt[i] <= periods[i];                   // Reload
                        ptr[i] <= ptr[i] + 1'b1;                // Wraps at table end
                    end else begin
                        cnt[i] <= cnt[i] - 1'b1;
                    end
                end
            end
        end
    end

    assign prod    = scc_pkg::wave_sample_t'(mem.rdata) * $signed({1'b0, volumes[voice]});
    assign contrib = voice_en[voice] ? scc_pkg::chip_wave_t'(prod >>> 4) : '0;

    // Sweep FSM
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            state <= scc_pkg::SEQ_IDLE;
            voice <= '0;
            acc   <= '0;
            wave  <= '0;
        end else begin
            case (state)
                scc_pkg::SEQ_IDLE: if (clk_en) begin
                    state <= scc_pkg::SEQ_FETCH;
                    voice <= '0;
                    acc   <= '0;
                end
                scc_pkg::SEQ_FETCH: if (mem.grant) state <= scc_pkg::SEQ_ACCUM;  // Stall while CPU owns RAM
                scc_pkg::SEQ_ACCUM: begin
                    if (voice == LAST_VOICE) begin
                        wave  <= acc + contrib;                 // Publish the finished sum
                        state <= scc_pkg::SEQ_IDLE;
                    end else begin
                        acc   <= acc + contrib;
                        voice <= voice + 1'b1;
                        state <= scc_pkg::SEQ_FETCH;
                    end
                end
                default: state <= scc_pkg::SEQ_IDLE;
            endcase
        end
    end

    // Address latched ahead of each fetch so it holds through a stall
    always_ff @(posedge cpu_bus) begin
        if (state == scc_pkg::SEQ_IDLE && clk_en)
            mem.addr <= fetch_addr(3'd0, ptr[0], plus_mode);
        else if (state == scc_pkg::SEQ_ACCUM && voice != LAST_VOICE)
            mem.addr <= fetch_addr(voice + 1'b1, ptr[voice + 1'b1], plus_mode);
    end

    assign mem.req   = state == scc_pkg::SEQ_FETCH;
    assign mem.we    = 1'b0;                                    // Read only
    assign mem.wdata = '0;

endmodule

// ==== design/scc_wave.sv ====
`timescale 1ns/1ns
`include "scc_config.svh"

module scc_wave (
    input  logic                   cpu_bus,
    input  logic                   rst_n,
    input  logic                   clk_en,
    input  logic                   sel,
    input  logic                   rd,
    input  logic                   wr,
    input  msx_bus_pkg::bus_addr_t addr,
    input  msx_bus_pkg::bus_byte_t wdata,
    input  logic                   plus_chip,   // Chip is an SCC+
    input  logic                   plus_mode,   // SCC+ map requested
    output scc_pkg::chip_wave_t    wave,
    output msx_bus_pkg::bus_byte_t rdata,
    output logic                   rvalid
);

    scc_pkg::voice_period_t periods [`SCC_NUM_VOICES];
    scc_pkg::voice_volume_t volumes [`SCC_NUM_VOICES];
    logic [`SCC_NUM_VOICES-1:0] voice_en;
    logic                   plus_eff;           // Mode honored only on SCC+ parts

    scc_wave_mem_if cpu_mem ();
    scc_wave_mem_if seq_mem ();

    assign plus_eff = plus_chip && plus_mode;

    scc_reg_port u_reg_port (
        .cpu_bus, .rst_n, .sel, .rd, .wr, .addr, .wdata,
        .plus_mode (plus_eff),
        .mem       (cpu_mem.requester),
        .periods, .volumes, .voice_en, .rdata, .rvalid
    );

    scc_voice_seq u_voice_seq (
        .cpu_bus, .rst_n, .clk_en, .periods, .volumes, .voice_en,
        .plus_mode (plus_eff),
        .mem       (seq_mem.requester),
        .wave
    );

    scc_wave_arb u_wave_arb (
        .cpu_bus, .rst_n,
        .cpu_mem (cpu_mem.arbiter),
        .seq_mem (seq_mem.arbiter)
    );

endmodule

// ==== design/scc_wave_arb.sv ====
`timescale 1ns/1ns
`include "scc_config.svh"

module scc_wave_arb (
    input  logic            cpu_bus,
    input  logic            rst_n,
    scc_wave_mem_if.arbiter cpu_mem,   // Register port, high priority
    scc_wave_mem_if.arbiter seq_mem    // Voice sequencer
);

    localparam int RAM_DEPTH = `SCC_NUM_VOICES * `SCC_WAVE_DEPTH;

    scc_pkg::wave_sample_t ram [RAM_DEPTH];   // Five tables back to back
    logic                  acc_req;           // Someone owns the port this cycle
    logic                  acc_we;
    scc_pkg::wave_index_t  acc_addr;
    scc_pkg::wave_sample_t acc_wdata;
    scc_pkg::wave_sample_t rd_q;              // Synchronous read result

    // Fixed priority, CPU wins
    assign cpu_mem.grant = cpu_mem.req;
    assign seq_mem.grant = seq_mem.req && !cpu_mem.req;

    // Single port steered to the winner
    always_comb begin
        acc_req = cpu_mem.req || seq_mem.req;
        if (cpu_mem.req) begin
            acc_we    = cpu_mem.we;
            acc_addr  = cpu_mem.addr;
            acc_wdata = cpu_mem.wdata;
        end else begin
            acc_we    = seq_mem.we;
            acc_addr  = seq_mem.addr;
            acc_wdata = seq_mem.wdata;
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (acc_req && acc_we)
            ram[acc_addr] <= acc_wdata;       // Write done in the grant cycle
    end

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n)
            rd_q <= '0;
        else if (acc_req && !acc_we)
            rd_q <= ram[acc_addr];            // Seen by the reader one cycle later
    end

    // Both sides see the same register, only the granted one samples it
    assign cpu_mem.rdata = rd_q;
    assign seq_mem.rdata = rd_q;

endmodule

// ==== design/scc_wave_mem_if.sv ====
`timescale 1ns/1ns

interface scc_wave_mem_if ();

    logic                  req;     // Held until grant
    logic                  we;      // Write when high, read when low
    scc_pkg::wave_index_t  addr;    // Table byte to access
    scc_pkg::wave_sample_t wdata;   // Byte to store
    logic                  grant;   // One cycle, access done at its edge
    scc_pkg::wave_sample_t rdata;   // Valid the cycle after a read grant

    // Side that asks for the memory
    modport requester (
        output req, we, addr, wdata,
        input  grant, rdata
    );

    // Side that owns the memory
    modport arbiter (
        input  req, we, addr, wdata,
        output grant, rdata
    );

endinterface

// ==== test/scc_assert.sv ====
`timescale 1ns/1ns

module scc_assert (
    input logic                   cpu_bus,
    input logic                   rst_n,
    input logic                   output_rq,
    input msx_bus_pkg::bus_byte_t data
);

    int fail_cnt = 0;   // Failed assertions so far

    // No read return while reset is held
    rq_in_reset: assert property (@(posedge cpu_bus) !rst_n |-> !output_rq)
        else begin
            fail_cnt++;
            $error("output_rq high during reset");
        end

    // Open bus value between read returns
    idle_data: assert property (@(posedge cpu_bus) disable iff (!rst_n)
                                !output_rq |-> data == 8'hFF)
        else begin
            fail_cnt++;
            $error("data not 0xFF while output_rq low");
        end

    // Read return is a single-cycle pulse
    single_pulse: assert property (@(posedge cpu_bus) disable iff (!rst_n)
                                   output_rq |=> !output_rq)
        else begin
            fail_cnt++;
            $error("output_rq high for two cycles");
        end

endmodule

bind scc_top scc_assert u_scc_assert (
    .cpu_bus   (cpu_bus),
    .rst_n     (rst_n),
    .output_rq (output_rq),
    .data      (data)
);

// ==== test/scc_tb.sv ====
`timescale 1ns/1ns
`include "scc_config.svh"

module scc_tb;

    localparam int RD_TIMEOUT     = 16;    // Cycles allowed for a read return
    localparam int SETTLE_TIMEOUT = 400;   // Cycles allowed for sound to settle

    logic                   cpu_bus;
    logic                   rst_n;
    logic                   clk_en;
    logic                   rd;
    logic                   wr;
    msx_bus_pkg::bus_addr_t addr;
    msx_bus_pkg::bus_byte_t wdata;
    msx_bus_pkg::dev_type_t dev_typ;
    msx_bus_pkg::dev_num_t  dev_num;
    logic                   dev_en;
    logic                   dev_mode;
    logic                   dev_param;
    logic [1:0]             mix_enable;
    scc_pkg::mix_sample_t   sound;
    msx_bus_pkg::bus_byte_t data;
    logic                   output_rq;

    logic [3:0]             tick_div;          // Sample tick every 16 clocks
    logic                   mode_flag [2];     // Flags each chip should hold
    logic                   plus_flag [2];
    msx_bus_pkg::bus_byte_t ref_mem [2][128];  // Bytes written to each chip
    integer                 seed;
    int                     errors;
    int                     checks;

    scc_top dut0 (.*);

    always #20 cpu_bus = ~cpu_bus;

    always @(posedge cpu_bus) begin
        tick_div <= tick_div + 1'b1;
        clk_en   <= (tick_div == 4'd15);
    end

    task automatic check_byte(input msx_bus_pkg::bus_byte_t got,
                              input msx_bus_pkg::bus_byte_t exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_sample(input scc_pkg::mix_sample_t got,
                                input scc_pkg::mix_sample_t exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Read return came %0d cycles after rd instead of %0d", got, exp);
        end
    endtask

    // Sample times volume over 16 for one voice
    function automatic scc_pkg::mix_sample_t voice_share(input scc_pkg::wave_sample_t s,
                                                         input scc_pkg::voice_volume_t v);
        int p;
        p = int'(s) * int'(v);
        return scc_pkg::mix_sample_t'(p >>> 4);
    endfunction

    task automatic drive_dev(input msx_bus_pkg::dev_num_t n, input logic en);
        dev_typ   <= msx_bus_pkg::DEV_SCC;
        dev_num   <= n;
        dev_en    <= en;
        dev_mode  <= mode_flag[n];   // Config bus rewrites flags on every SCC cycle
        dev_param <= plus_flag[n];
    endtask

    task automatic release_dev();
        dev_typ <= msx_bus_pkg::DEV_NONE;
        dev_en  <= 1'b0;
    endtask

    task automatic write_reg(input msx_bus_pkg::dev_num_t n, input msx_bus_pkg::bus_addr_t a,
                             input msx_bus_pkg::bus_byte_t d, input logic en = 1'b1);
        @(posedge cpu_bus);
        drive_dev(n, en);
        wr    <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge cpu_bus);
        wr <= 1'b0;
        release_dev();
        repeat (4) @(posedge cpu_bus);   // Gap between strobes
    endtask

    task automatic read_reg(input msx_bus_pkg::dev_num_t n, input msx_bus_pkg::bus_addr_t a,
                            output msx_bus_pkg::bus_byte_t val, output int lat);
        bit seen;
        seen = 1'b0;
        val  = 8'hFF;
        lat  = -1;
        @(posedge cpu_bus);
        drive_dev(n, 1'b1);
        rd   <= 1'b1;
        addr <= a;
        for (int i = 0; i < RD_TIMEOUT && !seen; i++) begin
            @(negedge cpu_bus);                    // Outputs stable mid-cycle
            if (output_rq) begin
                seen = 1'b1;
                val  = data;
                lat  = i;
            end else begin
                @(posedge cpu_bus);
                rd <= 1'b0;
                release_dev();
            end
        end
        if (!seen) begin
            errors++;
            $display("No read return from chip %0d at address 0x%h", n, a);
        end
        repeat (4) @(posedge cpu_bus);
    endtask

    task automatic fill_table(input msx_bus_pkg::dev_num_t n, input msx_bus_pkg::bus_addr_t base,
                              input scc_pkg::wave_sample_t s);
        for (int i = 0; i < `SCC_WAVE_DEPTH; i++)
            write_reg(n, msx_bus_pkg::bus_addr_t'(base + i), msx_bus_pkg::bus_byte_t'(s));
    endtask

    task automatic wait_sound(input scc_pkg::mix_sample_t exp);
        bit done;
        done = 1'b0;
        for (int i = 0; i < SETTLE_TIMEOUT && !done; i++) begin
            @(negedge cpu_bus);
            done = (sound == exp);
        end
        check_sample(sound, exp, "sound");
    endtask

    task automatic end_test(input string name, input int start);
        if (errors == start) $display("%-10s ok", name);
        else $display("%-10s %0d errors", name, errors - start);
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        @(negedge cpu_bus);
        checks++;
        if (output_rq !== 1'b0) begin
            errors++;
            $display("ERR output_rq: got 0x%h, expected 0x0", output_rq);
        end
        check_byte(data, 8'hFF, "data");
        check_sample(sound, '0, "sound");
        end_test("reset", start);
    endtask

    task automatic test_readback();
        int                     start;
        int                     lat;
        msx_bus_pkg::bus_byte_t got;
        start = errors;
        for (int c = 0; c < 2; c++)
            for (int i = 0; i < 16; i++) begin
                ref_mem[c][i*7] = msx_bus_pkg::bus_byte_t'($random(seed));
                write_reg(c, 8'(i*7), ref_mem[c][i*7]);
            end
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < 16; i++) begin
                read_reg(c, 8'(i*7), got, lat);
                check_byte(got, ref_mem[c][i*7], $sformatf("data chip%0d @%h", c, i*7));
                check_latency(lat, 2);
            end
            read_reg(c, `SCC_PERIOD_BASE, got, lat);   // Registers read as open bus
            check_byte(got, 8'hFF, "data period reg");
            check_latency(lat, 1);
            read_reg(c, `SCC_ENABLE_ADDR, got, lat);
            check_byte(got, 8'hFF, "data enable reg");
            check_latency(lat, 1);
        end
        end_test("readback", start);
    endtask

    task automatic test_isolation();
        int                     start;
        int                     lat;
        msx_bus_pkg::bus_byte_t got;
        start = errors;
        write_reg(0, 8'd7, ~ref_mem[0][7], 1'b0);      // Chip picked but dev_en low
        read_reg(0, 8'd7, got, lat);
        check_byte(got, ref_mem[0][7], "data chip0 dev_en low");
        ref_mem[1][7] = ~ref_mem[0][7];
        write_reg(1, 8'd7, ref_mem[1][7]);             // Other chip
        read_reg(0, 8'd7, got, lat);
        check_byte(got, ref_mem[0][7], "data chip0 other chip write");
        read_reg(1, 8'd7, got, lat);
        check_byte(got, ref_mem[1][7], "data chip1");
        end_test("isolation", start);
    endtask

    task automatic test_mixing();
        int                   start;
        scc_pkg::mix_sample_t e0;
        scc_pkg::mix_sample_t e1;
        start = errors;
        e0 = voice_share(8'sd100, 4'd15);
        e1 = voice_share(-8'sd77, 4'd9);
        fill_table(0, 8'h00, 8'sd100);
        fill_table(1, 8'h00, -8'sd77);
        write_reg(0, `SCC_VOLUME_BASE, 8'd15);
        write_reg(1, `SCC_VOLUME_BASE, 8'd9);
        write_reg(0, `SCC_ENABLE_ADDR, 8'h01);         // Voice 0 only
        write_reg(1, `SCC_ENABLE_ADDR, 8'h01);
        wait_sound(e0 + e1);
        @(posedge cpu_bus) mix_enable <= 2'b01;
        wait_sound(e0);
        @(posedge cpu_bus) mix_enable <= 2'b10;
        wait_sound(e1);
        end_test("mixing", start);
    endtask

    task automatic test_modes();
        int start;
        start = errors;
        @(posedge cpu_bus) mix_enable <= 2'b01;        // Chip 0 alone
        write_reg(0, `SCC_VOLUME_BASE + 4, 8'd8);
        write_reg(0, `SCC_ENABLE_ADDR, 8'h10);         // Voice 4 only
        fill_table(0, 8'h60, 8'sd60);                  // Voice 3 table shared in plain mode
        wait_sound(voice_share(8'sd60, 4'd8));
        mode_flag[0] = 1'b1;
        plus_flag[0] = 1'b1;
        @(posedge cpu_bus) drive_dev(0, 1'b0);         // Config cycle only
        @(posedge cpu_bus) release_dev();
        fill_table(0, `SCC_PLUS_WAVE4_BASE, -8'sd128);
        wait_sound(voice_share(-8'sd128, 4'd8));
        end_test("modes", start);
    endtask

    initial begin
        cpu_bus    = 1'b0;
        rst_n      = 1'b0;
        clk_en     = 1'b0;
        tick_div   = '0;
        rd         = 1'b0;
        wr         = 1'b0;
        addr       = '0;
        wdata      = '0;
        dev_typ    = msx_bus_pkg::DEV_NONE;
        dev_num    = '0;
        dev_en     = 1'b0;
        dev_mode   = 1'b0;
        dev_param  = 1'b0;
        mix_enable = 2'b11;
        mode_flag  = '{1'b0, 1'b0};
        plus_flag  = '{1'b0, 1'b0};
        seed       = 82261;
        errors     = 0;
        checks     = 0;
        repeat (8) @(posedge cpu_bus);
        rst_n <= 1'b1;
        test_reset();
        test_readback();
        test_isolation();
        test_mixing();
        test_modes();
        errors += dut0.u_scc_assert.fail_cnt;
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
